// ==== tk_sys_pkg.sv ====
/*
 * System package for the reset path and main RAM.
 * Address and data types, the RAM port request and the warm-start vector.
 */

`default_nettype none

package tk_sys_pkg;

    // ------------------------------------------------------------------------
    // Main RAM geometry
    // ------------------------------------------------------------------------

    // 64 KiB of CPU address space
    localparam int RAM_ADDR_W = 16;
    localparam int RAM_DATA_W = 8;
    localparam int RAM_DEPTH  = 1 << RAM_ADDR_W;

    typedef logic [RAM_ADDR_W-1:0] ram_addr_t;
    typedef logic [RAM_DATA_W-1:0] ram_data_t;

    // One request on the single RAM port
    typedef struct packed {
        ram_addr_t addr;
        ram_data_t data;
        logic      we;
    } ram_req_t;

    // ------------------------------------------------------------------------
    // Reset constants
    // ------------------------------------------------------------------------

    // Warm-start vector in page 3
    // Zeroed during reset so the ROM does a cold start
    localparam ram_addr_t RESET_VECTOR_ADDR = 16'h03F4;

endpackage

`default_nettype wire

// ==== tk_disk_pkg.sv ====
/*
 * Disk package for the track loader.
 * Track geometry, SD block addressing, buffer addressing and stage structs.
 */

`default_nettype none

package tk_disk_pkg;

    // ------------------------------------------------------------------------
    // Track geometry
    // ------------------------------------------------------------------------

    typedef logic [5:0]  track_t;
    typedef logic [3:0]  sector_idx_t;
    typedef logic [8:0]  byte_off_t;
    typedef logic [31:0] lba_t;

    // 13 sectors of 512 bytes hold one nibble track
    localparam int          SECTORS_PER_TRACK = 13;
    localparam sector_idx_t LAST_SECTOR       = 4'd12;

    // Buffer address is {sector, offset}
    localparam int TBUF_ADDR_W = $bits(sector_idx_t) + $bits(byte_off_t);
    localparam int TBUF_DEPTH  = 1 << TBUF_ADDR_W;

    typedef logic [TBUF_ADDR_W-1:0] tbuf_addr_t;

    // ------------------------------------------------------------------------
    // Stage structs
    // ------------------------------------------------------------------------

    // One byte write from the SD host buffer
    typedef struct packed {
        logic       wr;
        logic       ack;
        byte_off_t  off;
        logic [7:0] data;
    } sd_wr_t;

    // Track load request from the watcher to the fetcher
    typedef struct packed {
        logic   valid;
        track_t track;
    } load_req_t;

    typedef enum logic {
        FETCH_IDLE,
        FETCH_READ
    } fetch_state_t;

endpackage

`default_nettype wire

// ==== reset_seq.sv ====
/*
 * Reset sequencer.
 * Holds the core in reset for a power-on count after any source and
 * forces a zero write to the warm-start vector while reset is held.
 */

`timescale 1ns/1ps
`default_nettype none

module reset_seq #(
    parameter int POR_CNT_W = 23
) (
    input  logic                 clk_sys,
    input  logic                 reset_s,
    input  logic                 reset_req_i,
    input  tk_sys_pkg::ram_req_t cpu_ram_i,
    output logic                 core_reset_o,
    output tk_sys_pkg::ram_req_t ram_port_o
);

    import tk_sys_pkg::*;

    logic [POR_CNT_W-1:0] por_cnt;
    logic                 reset_src;

    // Board reset, menu, button or data pump
    assign reset_src = reset_s | reset_req_i;

    // ------------------------------------------------------------------------
    // Power-on counter
    // ------------------------------------------------------------------------

    always_ff @(posedge clk_sys) begin
        if (reset_src) begin
            // Restart the hold on every source pulse
            por_cnt      <= '0;
            core_reset_o <= 1'b1;
        end else begin
            // Release one cycle after the top bit sets
            if (por_cnt[POR_CNT_W-1]) begin
                core_reset_o <= 1'b0;
            end else begin
                por_cnt <= por_cnt + 1'b1;
            end
        end
    end

    // ------------------------------------------------------------------------
    // RAM guard
    // ------------------------------------------------------------------------

    // Clear the warm-start vector for the whole reset hold
    always_comb begin
        if (core_reset_o) begin
            ram_port_o.addr = RESET_VECTOR_ADDR;
            ram_port_o.data = '0;
            ram_port_o.we   = 1'b1;
        end else begin
            ram_port_o = cpu_ram_i;
        end
    end

    // RAM sees only the vector clear during reset
    a_guard_write : assert property (
        @(posedge clk_sys) core_reset_o |->
            (ram_port_o.we && ram_port_o.addr == RESET_VECTOR_ADDR && ram_port_o.data == '0)
    );

endmodule

`default_nettype wire

// ==== sys_ram.sv ====
/*
 * Main RAM model.
 * 64 KiB single port, write on we, read through one register.
 */

`timescale 1ns/1ps
`default_nettype none

module sys_ram (
    input  logic                  clk_sys,
    input  tk_sys_pkg::ram_req_t  ram_port_i,
    output tk_sys_pkg::ram_data_t rdata_o
);

    import tk_sys_pkg::*;

    // Byte array over the full CPU space
    ram_data_t mem [RAM_DEPTH];

    // ------------------------------------------------------------------------
    // Port
    // ------------------------------------------------------------------------

    always_ff @(posedge clk_sys) begin
        if (ram_port_i.we) begin
            mem[ram_port_i.addr] <= ram_port_i.data;
        end
        // Read-first, old data on a same-cycle write
        rdata_o <= mem[ram_port_i.addr];
    end

endmodule

`default_nettype wire

// ==== track_watch.sv ====
/*
 * Track watcher.
 * Spots a track change or a finished mount and issues one load request.
 */

`timescale 1ns/1ps
`default_nettype none

module track_watch (
    input  logic                   clk_sys,
    input  logic                   reset_s,
    input  tk_disk_pkg::track_t    track_i,
    input  logic                   img_mounted_i,
    input  logic                   img_size_nonzero_i,
    input  logic                   fetch_busy_i,
    output tk_disk_pkg::load_req_t load_req_o
);

    import tk_disk_pkg::*;

    track_t cur_track;
    logic   mount_seen;
    logic   req_q;
    logic   idle;
    logic   change;

    // Request cycle counts as busy so a request never doubles up
    assign idle = ~fetch_busy_i & ~req_q;

    // New track, or a mount pulse that has ended
    assign change = (track_i != cur_track) | (mount_seen & ~img_mounted_i);

    always_ff @(posedge clk_sys) begin
        if (reset_s) begin
            cur_track  <= '0;
            mount_seen <= 1'b0;
            req_q      <= 1'b0;
        end else begin
            req_q <= 1'b0;
            // Sticky until the idle check consumes it
            mount_seen <= mount_seen | img_mounted_i;
            if (idle && change) begin
                cur_track  <= track_i;
                mount_seen <= 1'b0;
                // No image means track moves silently
                req_q      <= img_size_nonzero_i;
            end
        end
    end

    // Track stays stable while the request is out
    assign load_req_o = '{valid: req_q, track: cur_track};

    a_no_req_busy : assert property (
        @(posedge clk_sys) disable iff (reset_s) !(load_req_o.valid && fetch_busy_i)
    );

endmodule

`default_nettype wire

// ==== sector_fetch.sv ====
/*
 * Sector fetcher.
 * Reads the 13 sectors of one track from the SD host, one ack per block,
 * and stalls the CPU until the first block is in.
 */

`timescale 1ns/1ps
`default_nettype none

module sector_fetch (
    input  logic                     clk_sys,
    input  logic                     reset_s,
    input  tk_disk_pkg::load_req_t   load_req_i,
    input  logic                     sd_ack_i,
    output logic                     sd_rd_o,
    output tk_disk_pkg::lba_t        sd_lba_o,
    output logic                     cpu_wait_o,
    output logic                     busy_o,
    output tk_disk_pkg::sector_idx_t sector_o
);

    import tk_disk_pkg::*;

    fetch_state_t state;
    logic         ack_q;
    logic         ack_rise;
    logic         ack_fall;

    // ------------------------------------------------------------------------
    // Ack edges
    // ------------------------------------------------------------------------

    always_ff @(posedge clk_sys) begin
        if (reset_s) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= sd_ack_i;
        end
    end

    assign ack_rise = sd_ack_i & ~ack_q;
    assign ack_fall = ~sd_ack_i & ack_q;

    // ------------------------------------------------------------------------
    // Fetch FSM
    // ------------------------------------------------------------------------

    always_ff @(posedge clk_sys) begin
        if (reset_s) begin
            state      <= FETCH_IDLE;
            sd_rd_o    <= 1'b0;
            cpu_wait_o <= 1'b0;
        end else begin
            case (state)
                FETCH_IDLE: begin
                    if (load_req_i.valid) begin
                        sector_o   <= '0;
                        // First block of the track
                        sd_lba_o   <= lba_t'(load_req_i.track) * lba_t'(SECTORS_PER_TRACK);
                        sd_rd_o    <= 1'b1;
                        cpu_wait_o <= 1'b1;
                        state      <= FETCH_READ;
                    end
                end
                FETCH_READ: begin
                    if (ack_rise) begin
                        // Host has latched the LBA, move to the next block
                        sd_lba_o <= sd_lba_o + 1'b1;
                        // Drop the read once the last block is under way
                        if (sector_o == LAST_SECTOR) begin
                            sd_rd_o <= 1'b0;
                        end
                    end else if (ack_fall) begin
                        sector_o   <= sector_o + 1'b1;
                        cpu_wait_o <= 1'b0;
                        if (!sd_rd_o) begin
                            state <= FETCH_IDLE;
                        end
                    end
                end
                default: begin
                    state <= FETCH_IDLE;
                end
            endcase
        end
    end

    assign busy_o = (state == FETCH_READ);

    // Sector counter wraps only after the FSM has left the read
    a_sector_range : assert property (
        @(posedge clk_sys) disable iff (reset_s) busy_o |-> (sector_o <= LAST_SECTOR)
    );

endmodule

`default_nettype wire

// ==== track_buffer.sv ====
/*
 * Track buffer.
 * Filled from SD buffer writes, read by the disk controller.
 */

`timescale 1ns/1ps
`default_nettype none

module track_buffer (
    input  logic                     clk_sys,
    input  tk_disk_pkg::sector_idx_t sector_i,
    input  tk_disk_pkg::sd_wr_t      sd_wr_i,
    input  tk_disk_pkg::tbuf_addr_t  rd_addr_i,
    output tk_sys_pkg::ram_data_t    rd_data_o
);

    import tk_disk_pkg::*;
    import tk_sys_pkg::*;

    // 8 KiB, top sectors above 12 stay unused
    ram_data_t  mem [TBUF_DEPTH];
    tbuf_addr_t wr_addr;
    logic       wr_en;

    // Sector picks the 512-byte slot
    assign wr_addr = {sector_i, sd_wr_i.off};

    // Strobe counts only inside an ack window
    assign wr_en = sd_wr_i.wr & sd_wr_i.ack;

    always_ff @(posedge clk_sys) begin
        if (wr_en) begin
            mem[wr_addr] <= sd_wr_i.data;
        end
    end

    // Controller side
    always_ff @(posedge clk_sys) begin
        rd_data_o <= mem[rd_addr_i];
    end

endmodule

`default_nettype wire

// ==== tk_disk_top.sv ====
/*
 * TK2000 floppy and reset top.
 * Reset sequencer with main RAM, and the three-stage track loader.
 */

`timescale 1ns/1ps
`default_nettype none

module tk_disk_top #(
    parameter int POR_CNT_W = 23
) (
    input  logic                    clk_sys,
    input  logic                    reset_s,
    // Reset and CPU side
    input  logic                    reset_req_i,
    input  tk_sys_pkg::ram_req_t    cpu_ram_i,
    output logic                    core_reset_o,
    output tk_sys_pkg::ram_data_t   ram_rdata_o,
    // Disk controller side
    input  tk_disk_pkg::track_t     track_i,
    input  tk_disk_pkg::tbuf_addr_t tbuf_rd_addr_i,
    output tk_sys_pkg::ram_data_t   tbuf_rd_data_o,
    output logic                    cpu_wait_o,
    // SD host side
    input  logic                    img_mounted_i,
    input  logic                    img_size_nonzero_i,
    input  logic                    sd_ack_i,
    input  logic                    sd_buff_wr_i,
    input  tk_disk_pkg::byte_off_t  sd_buff_addr_i,
    input  logic [7:0]              sd_buff_dout_i,
    output logic                    sd_rd_o,
    output tk_disk_pkg::lba_t       sd_lba_o
);

    import tk_sys_pkg::*;
    import tk_disk_pkg::*;

    ram_req_t    ram_port;
    load_req_t   load_req;
    logic        fetch_busy;
    sector_idx_t sector;
    sd_wr_t      sd_wr;

    // ------------------------------------------------------------------------
    // Reset path
    // ------------------------------------------------------------------------

    reset_seq #(
        .POR_CNT_W (POR_CNT_W)
    ) reset_seq_inst (
        .clk_sys      (clk_sys),
        .reset_s      (reset_s),
        .reset_req_i  (reset_req_i),
        .cpu_ram_i    (cpu_ram_i),
        .core_reset_o (core_reset_o),
        .ram_port_o   (ram_port)
    );

    sys_ram sys_ram_inst (
        .clk_sys    (clk_sys),
        .ram_port_i (ram_port),
        .rdata_o    (ram_rdata_o)
    );

    // ------------------------------------------------------------------------
    // Track loader
    // ------------------------------------------------------------------------

    // Loader stages run under core reset
    track_watch track_watch_inst (
        .clk_sys            (clk_sys),
        .reset_s            (core_reset_o),
        .track_i            (track_i),
        .img_mounted_i      (img_mounted_i),
        .img_size_nonzero_i (img_size_nonzero_i),
        .fetch_busy_i       (fetch_busy),
        .load_req_o         (load_req)
    );

    sector_fetch sector_fetch_inst (
        .clk_sys    (clk_sys),
        .reset_s    (core_reset_o),
        .load_req_i (load_req),
        .sd_ack_i   (sd_ack_i),
        .sd_rd_o    (sd_rd_o),
        .sd_lba_o   (sd_lba_o),
        .cpu_wait_o (cpu_wait_o),
        .busy_o     (fetch_busy),
        .sector_o   (sector)
    );

    assign sd_wr = '{wr: sd_buff_wr_i, ack: sd_ack_i, off: sd_buff_addr_i, data: sd_buff_dout_i};

    track_buffer track_buffer_inst (
        .clk_sys   (clk_sys),
        .sector_i  (sector),
        .sd_wr_i   (sd_wr),
        .rd_addr_i (tbuf_rd_addr_i),
        .rd_data_o (tbuf_rd_data_o)
    );

endmodule

`default_nettype wire

// ==== tb_sd_host.sv ====
/*
 * Behavioral SD host for the track loader testbench.
 * Answers each read with one ack pulse carrying 512 pattern bytes.
 */

`timescale 1ns/1ps
`default_nettype none

module tb_sd_host (
    input  logic                   clk_sys,
    input  logic                   sd_rd_i,
    input  tk_disk_pkg::lba_t      sd_lba_i,
    output logic                   sd_ack_o,
    output logic                   sd_buff_wr_o,
    output tk_disk_pkg::byte_off_t sd_buff_addr_o,
    output logic [7:0]             sd_buff_dout_o,
    output int                     ack_count_o,
    output int                     timeout_count_o
);

    import tk_disk_pkg::*;

    // Idle limit between loads, well past any single test phase
    localparam int RD_TIMEOUT = 20000;
    // One track never needs more blocks than this
    localparam int MAX_BLOCKS = 16;
    localparam int BLOCK_LEN  = 512;

    logic [31:0] lcg_state;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic idle_cycles(input int n);
        for (int i = 0; i < n; i++) begin
            @(posedge clk_sys);
            #1;
        end
    endtask

    // One block: ack up, 512 writes, ack down
    task automatic send_block();
        lba_t lba;
        lba_t sum;
        // LBA is latched as ack rises
        lba = sd_lba_i;
        sd_ack_o = 1'b1;
        ack_count_o++;
        for (int off = 0; off < BLOCK_LEN; off++) begin
            @(posedge clk_sys);
            #1;
            sum            = lba + lba_t'(off);
            sd_buff_wr_o   = 1'b1;
            sd_buff_addr_o = byte_off_t'(off);
            sd_buff_dout_o = sum[7:0];
        end
        @(posedge clk_sys);
        #1;
        sd_buff_wr_o = 1'b0;
        sd_ack_o     = 1'b0;
    endtask

    initial begin
        int wait_n;
        int gap;
        int blocks;
        sd_ack_o        = 1'b0;
        sd_buff_wr_o    = 1'b0;
        sd_buff_addr_o  = '0;
        sd_buff_dout_o  = '0;
        ack_count_o     = 0;
        timeout_count_o = 0;
        lcg_state       = 32'd57;
        forever begin
            wait_n = 0;
            while (!sd_rd_i && wait_n < RD_TIMEOUT) begin
                @(posedge clk_sys);
                #1;
                wait_n++;
            end
            if (!sd_rd_i) begin
                timeout_count_o++;
                $display("SD host: no read request within %0d cycles", RD_TIMEOUT);
            end else begin
                blocks = 0;
                while (sd_rd_i && blocks < MAX_BLOCKS) begin
                    // Random host latency of 1 to 8 cycles
                    lcg_state = lcg_step(lcg_state);
                    gap       = 1 + int'(lcg_state[18:16]);
                    idle_cycles(gap);
                    send_block();
                    blocks++;
                    @(posedge clk_sys);
                    #1;
                end
                if (sd_rd_i) begin
                    timeout_count_o++;
                    $display("SD host: read still requested after %0d blocks", MAX_BLOCKS);
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== tb_top.sv ====
/*
 * Testbench for the TK2000 floppy and reset top.
 * Reset hold, warm-start clear and track loads against a behavioral SD host.
 */

`timescale 1ns/1ps
`default_nettype none

module tb_top;

    import tk_sys_pkg::*;
    import tk_disk_pkg::*;

    localparam int POR_CNT_W    = 6;
    localparam int POR_HOLD     = 1 << (POR_CNT_W - 1);
    localparam int REL_TIMEOUT  = 4 * POR_HOLD;
    localparam int REQ_TIMEOUT  = 20;
    localparam int LOAD_TIMEOUT = 13 * 600;
    localparam int ACK_TIMEOUT  = 600;
    localparam int QUIET_CYCLES = 100;
    localparam int TRACK_BLOCKS = 13;
    // Sampled offsets within each sector
    localparam int OFFS [4] = '{0, 1, 255, 511};

    logic       clk_sys;
    logic       reset_s;
    logic       reset_req;
    ram_req_t   cpu_ram;
    ram_data_t  ram_rdata;
    logic       core_reset;
    track_t     track;
    tbuf_addr_t tbuf_rd_addr;
    ram_data_t  tbuf_rd_data;
    logic       cpu_wait;
    logic       img_mounted;
    logic       img_size_nonzero;
    logic       sd_ack;
    logic       sd_buff_wr;
    byte_off_t  sd_buff_addr;
    logic [7:0] sd_buff_dout;
    logic       sd_rd;
    lba_t       sd_lba;
    int         host_acks;
    int         host_timeouts;

    int   err_count;
    lba_t exp_lba;
    int   ack_idx;
    int   acks_before;
    logic ack_prev;

    initial begin
        clk_sys = 1'b0;
        forever #2 clk_sys = ~clk_sys;
    end

    tk_disk_top #(
        .POR_CNT_W (POR_CNT_W)
    ) tk_disk_top_inst (
        .clk_sys            (clk_sys),
        .reset_s            (reset_s),
        .reset_req_i        (reset_req),
        .cpu_ram_i          (cpu_ram),
        .core_reset_o       (core_reset),
        .ram_rdata_o        (ram_rdata),
        .track_i            (track),
        .tbuf_rd_addr_i     (tbuf_rd_addr),
        .tbuf_rd_data_o     (tbuf_rd_data),
        .cpu_wait_o         (cpu_wait),
        .img_mounted_i      (img_mounted),
        .img_size_nonzero_i (img_size_nonzero),
        .sd_ack_i           (sd_ack),
        .sd_buff_wr_i       (sd_buff_wr),
        .sd_buff_addr_i     (sd_buff_addr),
        .sd_buff_dout_i     (sd_buff_dout),
        .sd_rd_o            (sd_rd),
        .sd_lba_o           (sd_lba)
    );

    tb_sd_host tb_sd_host_inst (
        .clk_sys         (clk_sys),
        .sd_rd_i         (sd_rd),
        .sd_lba_i        (sd_lba),
        .sd_ack_o        (sd_ack),
        .sd_buff_wr_o    (sd_buff_wr),
        .sd_buff_addr_o  (sd_buff_addr),
        .sd_buff_dout_o  (sd_buff_dout),
        .ack_count_o     (host_acks),
        .timeout_count_o (host_timeouts)
    );

    // ------------------------------------------------------------------------
    // Ack monitor, sampled mid-cycle
    // ------------------------------------------------------------------------

    always @(negedge clk_sys) begin
        if (sd_ack && !ack_prev) begin
            // LBA steps by one per block
            a_lba_seq : assert (sd_lba == exp_lba) else begin
                err_count++;
                $display("ERR %0t: LBA %0d at ack, expected %0d", $time, sd_lba, exp_lba);
            end
            // CPU stalled only until the first block ends
            a_wait_first : assert (cpu_wait == (ack_idx == 0)) else begin
                err_count++;
                $display("ERR %0t: cpu_wait_o %0b at ack %0d", $time, cpu_wait, ack_idx);
            end
            exp_lba = exp_lba + 1;
            ack_idx++;
        end
        ack_prev = sd_ack;
    end

    a_wait_in_read : assert property (
        @(posedge clk_sys) disable iff (core_reset) cpu_wait |-> sd_rd
    ) else begin
        err_count++;
        $display("ERR %0t: cpu_wait_o high with no read in progress", $time);
    end

    // ------------------------------------------------------------------------
    // Tasks
    // ------------------------------------------------------------------------

    task automatic fail_timeout(input string what);
        $display("Timeout: %s", what);
        $display("*** TEST FAILED ***");
        $finish;
    endtask

    task automatic wait_core_release(output int cycles);
        cycles = 0;
        while (core_reset && cycles < REL_TIMEOUT) begin
            @(posedge clk_sys);
            #1;
            cycles++;
        end
        if (core_reset) fail_timeout("core reset was never released");
    endtask

    task automatic ram_write(input ram_addr_t addr, input ram_data_t data);
        cpu_ram = '{addr: addr, data: data, we: 1'b1};
        @(posedge clk_sys);
        #1;
        cpu_ram.we = 1'b0;
    endtask

    // Registered read, data one cycle after the address
    task automatic ram_check(input ram_addr_t addr, input ram_data_t expected);
        cpu_ram = '{addr: addr, data: '0, we: 1'b0};
        @(posedge clk_sys);
        #1;
        a_ram_data : assert (ram_rdata == expected) else begin
            err_count++;
            $display("ERR %0t: RAM[%h] = %h, expected %h", $time, addr, ram_rdata, expected);
        end
    endtask

    task automatic arm_load_checks(input lba_t first_lba);
        exp_lba     = first_lba;
        ack_idx     = 0;
        acks_before = host_acks;
    endtask

    task automatic wait_load(input string what);
        int n;
        n = 0;
        while (!sd_rd && n < REQ_TIMEOUT) begin
            @(posedge clk_sys);
            #1;
            n++;
        end
        if (!sd_rd) begin
            fail_timeout({"no SD read after ", what});
        end else begin
            a_wait_start : assert (cpu_wait) else begin
                err_count++;
                $display("ERR %0t: cpu_wait_o low at load start", $time);
            end
            n = 0;
            while (sd_rd && n < LOAD_TIMEOUT) begin
                @(posedge clk_sys);
                #1;
                n++;
            end
            if (sd_rd) begin
                fail_timeout({"SD read never ended after ", what});
            end else begin
                // Last block still streams after the read drops
                n = 0;
                while (sd_ack && n < ACK_TIMEOUT) begin
                    @(posedge clk_sys);
                    #1;
                    n++;
                end
                if (sd_ack) begin
                    fail_timeout({"last SD block never ended after ", what});
                end else begin
                    repeat (2) @(posedge clk_sys);
                    #1;
                    a_ack_count : assert (host_acks - acks_before == TRACK_BLOCKS) else begin
                        err_count++;
                        $display("ERR %0t: %0d acks for one track, expected %0d",
                                 $time, host_acks - acks_before, TRACK_BLOCKS);
                    end
                end
            end
        end
    endtask

    // Each byte holds the low byte of its block LBA plus offset
    task automatic tbuf_check(input lba_t first_lba);
        lba_t sum;
        int   o;
        for (int s = 0; s < TRACK_BLOCKS; s++) begin
            for (int k = 0; k < 4; k++) begin
                o            = OFFS[k];
                tbuf_rd_addr = {sector_idx_t'(s), byte_off_t'(o)};
                @(posedge clk_sys);
                #1;
                sum = first_lba + lba_t'(s) + lba_t'(o);
                a_tbuf_data : assert (tbuf_rd_data == sum[7:0]) else begin
                    err_count++;
                    $display("ERR %0t: buffer sector %0d offset %0d = %h, expected %h",
                             $time, s, o, tbuf_rd_data, sum[7:0]);
                end
            end
        end
    endtask

    // ------------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------------

    initial begin
        int n;
        reset_s          = 1'b1;
        reset_req        = 1'b0;
        cpu_ram          = '0;
        track            = '0;
        tbuf_rd_addr     = '0;
        img_mounted      = 1'b0;
        img_size_nonzero = 1'b1;
        err_count        = 0;
        exp_lba          = '0;
        ack_idx          = 0;
        acks_before      = 0;
        ack_prev         = 1'b0;
        repeat (16) @(posedge clk_sys);
        #1;
        reset_s = 1'b0;

        // Power-on hold after board reset
        wait_core_release(n);
        a_por_hold : assert (n >= POR_HOLD) else begin
            err_count++;
            $display("ERR %0t: core reset held %0d cycles, expected %0d", $time, n, POR_HOLD);
        end
        a_loader_idle : assert (!sd_rd && !cpu_wait) else begin
            err_count++;
            $display("ERR %0t: loader not idle after reset", $time);
        end

        // Warm-start vector cleared by a reset request
        ram_write(RESET_VECTOR_ADDR, 8'h5A);
        ram_write(16'h0100, 8'h5A);
        ram_check(RESET_VECTOR_ADDR, 8'h5A);
        reset_req = 1'b1;
        @(posedge clk_sys);
        #1;
        reset_req = 1'b0;
        wait_core_release(n);
        a_req_hold : assert (n >= POR_HOLD) else begin
            err_count++;
            $display("ERR %0t: request hold %0d cycles, expected %0d", $time, n, POR_HOLD);
        end
        ram_check(RESET_VECTOR_ADDR, 8'h00);
        ram_check(16'h0100, 8'h5A);

        // Track change with an image present
        arm_load_checks(lba_t'(65));
        track = 6'd5;
        wait_load("track change to 5");
        tbuf_check(lba_t'(65));

        // No image, no load
        img_size_nonzero = 1'b0;
        @(posedge clk_sys);
        #1;
        track = 6'd9;
        for (int i = 0; i < QUIET_CYCLES; i++) begin
            @(posedge clk_sys);
            #1;
            a_no_image : assert (!sd_rd) else begin
                err_count++;
                $display("ERR %0t: SD read with no image present", $time);
            end
        end

        // Mount pulse loads the current track
        img_size_nonzero = 1'b1;
        arm_load_checks(lba_t'(117));
        img_mounted = 1'b1;
        @(posedge clk_sys);
        #1;
        img_mounted = 1'b0;
        wait_load("mount pulse");
        tbuf_check(lba_t'(117));

        $display("Summary: %0d check errors, %0d SD host timeouts", err_count, host_timeouts);
        if (err_count == 0 && host_timeouts == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
tk_sys_pkg.sv
tk_disk_pkg.sv
reset_seq.sv
sys_ram.sv
track_watch.sv
sector_fetch.sv
track_buffer.sv
tk_disk_top.sv
tb_sd_host.sv
tb_top.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_top \
    --Mdir obj_dir -o sim_tb -f all.f
./obj_dir/sim_tb | tee sim.log
if grep -q "TEST PASSED" sim.log; then
    echo "Simulation result: pass"
else
    echo "Simulation result: fail"
    exit 1
fi
